// File: include/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// request channels served by the scheduler
`define SCHED_CHAN_COUNT 6
`define SCHED_DEADLINE_W 8
// ceiling log2 of the channel count
`define SCHED_CHAN_IDX_W 3

`endif

// File: src/sched_data_pkg.sv
`include "sched_defines.svh"

package sched_data_pkg;

    // deadline or horizon value
    typedef logic [`SCHED_DEADLINE_W-1:0] deadline_t;

    // one bit per channel, used for pending, winner and clear
    typedef logic [`SCHED_CHAN_COUNT-1:0] chan_mask_t;

    typedef logic [`SCHED_CHAN_IDX_W-1:0] chan_idx_t; // channel number

endpackage

// File: src/sched_ctrl_pkg.sv
`include "sched_defines.svh"

package sched_ctrl_pkg;

    // grant issue FSM
    typedef enum logic [1:0] {
        ISSUE_IDLE,   // sample eligibility
        ISSUE_GRANT,  // grant pulse and slot clear
        ISSUE_SETTLE  // tree sees the cleared slot
    } issue_state_t;

endpackage

// File: src/deadline_slots.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module deadline_slots (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             push,
    input  sched_data_pkg::chan_idx_t                        push_chan,
    input  sched_data_pkg::deadline_t                        push_deadline,
    input  sched_data_pkg::chan_mask_t                       clear_mask,
    output sched_data_pkg::chan_mask_t                       pending,
    output logic [`SCHED_CHAN_COUNT*`SCHED_DEADLINE_W-1:0] slot_deadlines
);

    import sched_data_pkg::*;

    chan_mask_t push_hit;
    deadline_t  slot_q [`SCHED_CHAN_COUNT];

    // out of range channel numbers shift out of the mask and are dropped
    assign push_hit = push ? (chan_mask_t'(1) << push_chan) : '0;

    // push wins over a clear of the same slot
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | push_hit;
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            if (push_hit[c]) begin
                slot_q[c] <= push_deadline; // overwrite on repeated push
            end
        end
    end

    // flatten for the comparison tree, channel 0 in the low bits
    genvar g;
    generate
        for (g = 0; g < `SCHED_CHAN_COUNT; g++) begin : g_flat
            assign slot_deadlines[g*`SCHED_DEADLINE_W +: `SCHED_DEADLINE_W] = slot_q[g];
        end
    endgenerate

endmodule

// File: src/min_index_tree.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

// log depth minimum search over the pending slots
// each node carries the winner mask of its subtree, zero when nothing is valid
module min_index_tree (
    input  sched_data_pkg::chan_mask_t                       pending,
    input  logic [`SCHED_CHAN_COUNT*`SCHED_DEADLINE_W-1:0] slot_deadlines,
    output sched_data_pkg::deadline_t                        min_deadline,
    output sched_data_pkg::chan_mask_t                       win_mask
);

    import sched_data_pkg::*;

    localparam int DEPTH  = $clog2(`SCHED_CHAN_COUNT);
    localparam int LEAVES = 2 ** DEPTH;
    localparam int NODES  = 2 * LEAVES - 1; // 8 + 4 + 2 + 1
    localparam int ROOT   = NODES - 1;

    deadline_t  node_val  [NODES];
    chan_mask_t node_mask [NODES];

    genvar i, j;
    generate
        for (i = 0; i < LEAVES; i++) begin : g_leaf
            if (i < `SCHED_CHAN_COUNT) begin : g_real
                assign node_val[i]  = slot_deadlines[i*`SCHED_DEADLINE_W +: `SCHED_DEADLINE_W];
                assign node_mask[i] = pending[i] ? (chan_mask_t'(1) << i) : '0;
            end else begin : g_pad
                assign node_val[i]  = '0;
                assign node_mask[i] = '0; // padding leaf never wins
            end
        end

        for (i = 0; i < DEPTH; i++) begin : g_layer
            localparam int BASE      = 2 ** (DEPTH + 1) - 2 ** (DEPTH - i);
            localparam int PREV_BASE = 2 ** (DEPTH + 1) - 2 ** (DEPTH + 1 - i);
            for (j = 0; j < 2 ** (DEPTH - 1 - i); j++) begin : g_node
                localparam int C1 = PREV_BASE + 2 * j;
                localparam int C2 = C1 + 1;
                logic v1, v2, take_c1;

                assign v1 = |node_mask[C1];
                assign v2 = |node_mask[C2];
                // second child unless first is strictly smaller, so ties go high
                assign take_c1 = v1 && (!v2 || (node_val[C1] < node_val[C2]));

                assign node_val[BASE + j]  = take_c1 ? node_val[C1] :
                                             (v2 ? node_val[C2] : '0);
                assign node_mask[BASE + j] = take_c1 ? node_mask[C1] : node_mask[C2];
            end
        end
    endgenerate

    assign min_deadline = node_val[ROOT];
    assign win_mask     = node_mask[ROOT];

endmodule

// File: src/grant_issue.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module grant_issue (
    input  logic                       clk,
    input  logic                       rst,
    input  sched_data_pkg::deadline_t  min_deadline,
    input  sched_data_pkg::chan_mask_t win_mask,
    input  sched_data_pkg::deadline_t  horizon,
    input  logic                       issue_en,
    output logic                       grant,
    output sched_data_pkg::chan_idx_t  grant_chan,
    output sched_data_pkg::deadline_t  grant_deadline,
    output sched_data_pkg::chan_mask_t clear_mask
);

    import sched_data_pkg::*;
    import sched_ctrl_pkg::*;

    issue_state_t state;
    chan_mask_t   win_q;
    logic         eligible;

    // one-hot mask to channel number
    function automatic chan_idx_t mask_to_idx(input chan_mask_t mask);
        chan_idx_t idx;
        idx = '0;
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            if (mask[c]) begin
                idx = chan_idx_t'(c);
            end
        end
        return idx;
    endfunction

    // nonzero mask means something is pending
    assign eligible = (|win_mask) && (min_deadline < horizon) && issue_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ISSUE_IDLE;
        end else begin
            case (state)
                ISSUE_IDLE:   state <= eligible ? ISSUE_GRANT : ISSUE_IDLE;
                ISSUE_GRANT:  state <= ISSUE_SETTLE; // slot clears on this edge
                ISSUE_SETTLE: state <= ISSUE_IDLE;
                default:      state <= ISSUE_IDLE;
            endcase
        end
    end

    // winner held for the whole grant cycle, later pushes do not disturb it
    always_ff @(posedge clk) begin
        if (state == ISSUE_IDLE && eligible) begin
            win_q          <= win_mask;
            grant_chan     <= mask_to_idx(win_mask);
            grant_deadline <= min_deadline;
        end
    end

    assign grant      = (state == ISSUE_GRANT);
    assign clear_mask = grant ? win_q : '0;

endmodule

// File: src/deadline_scheduler.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module deadline_scheduler (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  sched_data_pkg::chan_idx_t  push_chan,
    input  sched_data_pkg::deadline_t  push_deadline,
    input  sched_data_pkg::deadline_t  horizon,
    input  logic                       issue_en,
    output logic                       grant,
    output sched_data_pkg::chan_idx_t  grant_chan,
    output sched_data_pkg::deadline_t  grant_deadline,
    output sched_data_pkg::chan_mask_t pending
);

    import sched_data_pkg::*;

    logic [`SCHED_CHAN_COUNT*`SCHED_DEADLINE_W-1:0] slot_deadlines;
    deadline_t  min_deadline;
    chan_mask_t win_mask;
    chan_mask_t clear_mask; // fed back from the issuer

    deadline_slots deadline_slots_inst (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .push_chan      (push_chan),
        .push_deadline  (push_deadline),
        .clear_mask     (clear_mask),
        .pending        (pending),
        .slot_deadlines (slot_deadlines)
    );

    min_index_tree min_index_tree_inst (
        .pending        (pending),
        .slot_deadlines (slot_deadlines),
        .min_deadline   (min_deadline),
        .win_mask       (win_mask)
    );

    grant_issue grant_issue_inst (
        .clk            (clk),
        .rst            (rst),
        .min_deadline   (min_deadline),
        .win_mask       (win_mask),
        .horizon        (horizon),
        .issue_en       (issue_en),
        .grant          (grant),
        .grant_chan     (grant_chan),
        .grant_deadline (grant_deadline),
        .clear_mask     (clear_mask)
    );

endmodule

// File: testbench/deadline_scheduler_asserts.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module deadline_scheduler_asserts (
    input logic                       clk,
    input logic                       rst,
    input logic                       grant,
    input sched_data_pkg::chan_idx_t  grant_chan,
    input sched_data_pkg::chan_mask_t pending,
    input sched_data_pkg::chan_mask_t clear_mask
);

    grant_single_cycle: assert property (@(posedge clk) disable iff (rst)
        grant |=> !grant)
        else $error("grant held for two cycles");

    clear_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(clear_mask))
        else $error("clear_mask has more than one bit set");

    // issuer needs the settle cycle before it can sample again
    grant_spacing: assert property (@(posedge clk) disable iff (rst)
        grant |=> !grant [*2])
        else $error("grants closer than three cycles");

    grant_slot_pending: assert property (@(posedge clk) disable iff (rst)
        grant |-> pending[grant_chan])
        else $error("granted channel not pending");

endmodule

bind deadline_scheduler deadline_scheduler_asserts deadline_scheduler_asserts_inst (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .grant_chan (grant_chan),
    .pending    (pending),
    .clear_mask (clear_mask)
);

// File: testbench/deadline_scheduler_tb.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module deadline_scheduler_tb;

    import sched_data_pkg::*;

    localparam int CYCLE_LIMIT = 2000; // tests need a few hundred cycles

    logic       clk;
    logic       rst;
    logic       push;
    chan_idx_t  push_chan;
    deadline_t  push_deadline;
    deadline_t  horizon;
    logic       issue_en;
    logic       grant;
    chan_idx_t  grant_chan;
    deadline_t  grant_deadline;
    chan_mask_t pending;

    logic        model_pend [`SCHED_CHAN_COUNT];
    deadline_t   model_dl   [`SCHED_CHAN_COUNT];
    int          errors = 0;
    int          cycles = 0;
    int          grant_wait;

    deadline_scheduler deadline_scheduler_inst (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .push_chan      (push_chan),
        .push_deadline  (push_deadline),
        .horizon        (horizon),
        .issue_en       (issue_en),
        .grant          (grant),
        .grant_chan     (grant_chan),
        .grant_deadline (grant_deadline),
        .pending        (pending)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout: no end of tests after %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    function automatic chan_mask_t model_mask();
        chan_mask_t m;
        m = '0;
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            m[c] = model_pend[c];
        end
        return m;
    endfunction

    // lowest pending deadline, equal deadlines go to the higher channel
    function automatic logic predict_winner(output chan_idx_t chan, output deadline_t dl);
        logic found;
        found = 1'b0;
        chan  = '0;
        dl    = '0;
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            if (model_pend[c] && (!found || model_dl[c] <= dl)) begin
                found = 1'b1;
                chan  = chan_idx_t'(c);
                dl    = model_dl[c];
            end
        end
        return found && (dl < horizon) && issue_en;
    endfunction

    task automatic check_deadline(input string name, input deadline_t got, input deadline_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_chan(input string name, input chan_idx_t got, input chan_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    task automatic push_request(input chan_idx_t chan, input deadline_t dl);
        @(posedge clk);
        push          <= 1'b1;
        push_chan     <= chan;
        push_deadline <= dl;
        @(posedge clk); // DUT samples the push here
        push <= 1'b0;
        model_pend[chan] = 1'b1;
        model_dl[chan]   = dl;
    endtask

    // outputs are checked at the falling edge where they are settled
    task automatic expect_grant(input int max_edges);
        chan_idx_t exp_chan;
        deadline_t exp_dl;
        if (!predict_winner(exp_chan, exp_dl)) begin
            errors++;
            $display("a grant was expected but the model has no eligible request");
        end
        grant_wait = 0;
        do begin
            @(negedge clk);
            grant_wait++;
        end while (!grant && grant_wait < max_edges);
        if (!grant) begin
            errors++;
            $display("grant for channel %0d did not arrive within %0d cycles",
                     exp_chan, max_edges);
        end else begin
            check_chan("grant_chan", grant_chan, exp_chan);
            check_deadline("grant_deadline", grant_deadline, exp_dl);
        end
        model_pend[exp_chan] = 1'b0;
    endtask

    task automatic drain_grants();
        chan_idx_t c;
        deadline_t d;
        @(negedge clk); // enable and horizon driven at the last edge take effect first
        while (predict_winner(c, d)) begin
            expect_grant(4);
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if (grant) begin
                errors++;
                $display("unexpected grant on channel %0d with deadline %0d",
                         grant_chan, grant_deadline);
            end
        end
        check_mask("pending", pending, model_mask());
    endtask

    task automatic test_single();
        deadline_t d;
        d = deadline_t'($urandom % 255);
        @(posedge clk);
        horizon  <= 8'hFF;
        issue_en <= 1'b1;
        push_request(3'd2, d);
        expect_grant(2);
        if (grant && grant_wait != 2) begin
            errors++;
            $display("grant came %0d cycles after the push instead of 2", grant_wait);
        end
        expect_quiet(3);
    endtask

    task automatic test_random_order();
        deadline_t d;
        logic      dup;
        @(posedge clk);
        issue_en <= 1'b0;
        horizon  <= 8'hFF;
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            do begin
                d   = deadline_t'($urandom % 255);
                dup = 1'b0;
                for (int k = 0; k < c; k++) begin
                    dup |= (model_dl[k] == d);
                end
            end while (dup);
            push_request(chan_idx_t'(c), d);
        end
        @(posedge clk);
        issue_en <= 1'b1;
        drain_grants();
        expect_quiet(4);
    endtask

    task automatic test_ties();
        chan_idx_t order [3];
        order = '{3'd4, 3'd2, 3'd1};
        @(posedge clk);
        issue_en <= 1'b0;
        push_request(3'd1, 8'd77);
        push_request(3'd4, 8'd77);
        push_request(3'd2, 8'd77);
        @(posedge clk);
        issue_en <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            expect_grant(4);
            check_chan("grant_chan", grant_chan, order[i]);
        end
        expect_quiet(4);
    endtask

    task automatic test_horizon();
        @(posedge clk);
        issue_en <= 1'b0;
        horizon  <= 8'd100;
        push_request(3'd0, 8'd30);
        push_request(3'd1, 8'd120);
        push_request(3'd2, 8'd100); // equal to horizon, held back
        push_request(3'd5, 8'd60);
        @(posedge clk);
        issue_en <= 1'b1;
        drain_grants();
        expect_quiet(8);
        @(posedge clk);
        horizon <= 8'd20;
        push_request(3'd3, 8'd40);
        expect_quiet(8);
        @(posedge clk);
        horizon <= 8'hFF;
        drain_grants();
        expect_quiet(4);
    endtask

    task automatic test_hold();
        @(posedge clk);
        issue_en <= 1'b0;
        push_request(3'd0, 8'd50);
        push_request(3'd1, 8'd70);
        push_request(3'd4, 8'd90);
        expect_quiet(6);
        check_mask("pending", pending, 6'b010011);
        push_request(3'd4, 8'd10); // overwrite while held
        expect_quiet(2);
        @(posedge clk);
        issue_en <= 1'b1;
        drain_grants();
        expect_quiet(4);
    endtask

    task automatic test_push_in_grant();
        @(posedge clk);
        issue_en <= 1'b0;
        push_request(3'd3, 8'd50);
        @(posedge clk);
        issue_en <= 1'b1;
        @(posedge clk); // eligibility sampled here, grant cycle follows
        push          <= 1'b1;
        push_chan     <= 3'd3;
        push_deadline <= 8'd20;
        expect_grant(1);
        @(posedge clk); // push and clear meet on this edge
        push <= 1'b0;
        model_pend[3] = 1'b1;
        model_dl[3]   = 8'd20;
        expect_grant(4);
        expect_quiet(4);
    endtask

    initial begin
        void'($urandom(73508));
        clk           = 1'b0;
        rst           = 1'b1;
        push          = 1'b0;
        push_chan     = '0;
        push_deadline = '0;
        horizon       = '0;
        issue_en      = 1'b0;
        for (int c = 0; c < `SCHED_CHAN_COUNT; c++) begin
            model_pend[c] = 1'b0;
            model_dl[c]   = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        expect_quiet(2);
        test_single();
        test_random_order();
        test_ties();
        test_horizon();
        test_hold();
        test_push_in_grant();
        $display("errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/sched_data_pkg.sv
src/sched_ctrl_pkg.sv
src/deadline_slots.sv
src/min_index_tree.sv
src/grant_issue.sv
src/deadline_scheduler.sv
testbench/deadline_scheduler_asserts.sv
testbench/deadline_scheduler_tb.sv

// File: Bender.yml
package:
  name: deadline_scheduler

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/sched_data_pkg.sv
      - src/sched_ctrl_pkg.sv
      - src/deadline_slots.sv
      - src/min_index_tree.sv
      - src/grant_issue.sv
      - src/deadline_scheduler.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/deadline_scheduler_asserts.sv
      - testbench/deadline_scheduler_tb.sv
